/* verilog/pct_consts.svh */
`ifndef PCT_CONSTS_SVH
`define PCT_CONSTS_SVH

// Trace unit sizing
`define PCT_NUM_TRIGGERS 4
`define PCT_FIFO_DEPTH   8
`define PCT_STAMP_W      16
`define PCT_APB_AW       8

// APB byte offsets, one 32-bit word each
`define PCT_REG_CTRL        8'h00
`define PCT_REG_TRIG_EN     8'h04
`define PCT_REG_TRIG_ADDR0  8'h10
`define PCT_REG_TRIG_ADDR1  8'h14
`define PCT_REG_TRIG_ADDR2  8'h18
`define PCT_REG_TRIG_ADDR3  8'h1C
`define PCT_REG_WATCH_CFG   8'h20
`define PCT_REG_WATCH_VALUE 8'h24
`define PCT_REG_WATCH_MASK  8'h28
`define PCT_REG_STATUS      8'h30
`define PCT_REG_HEAD_PC     8'h34
`define PCT_REG_HEAD_INFO   8'h38

`endif

/* verilog/pct_pkg.sv */
`include "pct_consts.svh"

package pct_pkg;

  // --------------------------------------------------
  // Retire stream
  // --------------------------------------------------
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
  } retire_t;

  // --------------------------------------------------
  // Data watchpoint configuration
  // --------------------------------------------------
  typedef enum logic [2:0] {
    sel_r1 = 3'd0,
    sel_r2 = 3'd1,
    sel_r3 = 3'd2,
    sel_r4 = 3'd3,
    sel_r5 = 3'd4
  } watch_sel_e;

  typedef enum logic [1:0] {
    watch_off    = 2'd0,
    watch_equal  = 2'd1,
    watch_change = 2'd2
  } watch_mode_e;

  typedef struct packed {
    watch_mode_e mode;
    watch_sel_e  sel;
    logic [31:0] value;
    logic [31:0] mask;
  } watch_cfg_t;

  // --------------------------------------------------
  // Detector results and trace records
  // --------------------------------------------------
  // Detector outputs, one cycle after the retire
  typedef struct packed {
    logic                         valid;
    logic [31:0]                  pc;
    logic [`PCT_NUM_TRIGGERS-1:0] trig_hits;
    logic                         watch_hit;
  } hit_t;

  typedef struct packed {
    logic [31:0]                  pc;
    logic [`PCT_STAMP_W-1:0]      stamp;
    logic                         watch_hit;
    logic [`PCT_NUM_TRIGGERS-1:0] trig_hits;
  } trace_rec_t;

  typedef struct packed {
    logic [$clog2(`PCT_FIFO_DEPTH+1)-1:0] count;
    logic                                 empty;
    logic                                 overflow;
  } fifo_status_t;

endpackage

/* verilog/pc_trigger_match.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module pc_trigger_match (
  input  logic                               clks,
  input  logic                               rst_n,
  input  pct_pkg::retire_t                   retire,
  input  logic [`PCT_NUM_TRIGGERS-1:0]       trig_en,
  input  logic [`PCT_NUM_TRIGGERS-1:0][31:0] trig_addr,
  output logic [`PCT_NUM_TRIGGERS-1:0]       trig_hits,
  output logic [31:0]                        hit_pc,
  output logic                               hit_valid
);

  logic [`PCT_NUM_TRIGGERS-1:0] match;

  // --------------------------------------------------
  // Address compare
  // --------------------------------------------------
  // Full-word compare against each enabled trigger,
  // several triggers can fire on the same pc
  always_comb begin
    match = '0;
    for (int i = 0; i < `PCT_NUM_TRIGGERS; i++) begin
      match[i] = trig_en[i] && (retire.pc == trig_addr[i]);
    end
  end

  // --------------------------------------------------
  // Result register
  // --------------------------------------------------
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      hit_valid <= 1'b0;
      trig_hits <= '0;
    end else begin
      hit_valid <= retire.valid;
      // Idle cycles carry no hits
      if (retire.valid) begin
        trig_hits <= match;
      end else begin
        trig_hits <= '0;
      end
    end
  end

  // Pc travels with the hit vector
  always_ff @(posedge clks) begin
    if (retire.valid) begin
      hit_pc <= retire.pc;
    end
  end

endmodule

/* verilog/data_watch.sv */
`timescale 1ns/1ps

module data_watch (
  input  logic                clks,
  input  logic                rst_n,
  input  pct_pkg::retire_t    retire,
  input  pct_pkg::watch_cfg_t watch_cfg,
  output logic                watch_hit
);

  logic [31:0] sel_val;
  logic [31:0] prev_val;
  logic        seen_first;
  logic        equal_hit;
  logic        change_hit;

  // Register picked by the configuration
  always_comb begin
    case (watch_cfg.sel)
      pct_pkg::sel_r1: sel_val = retire.r1;
      pct_pkg::sel_r2: sel_val = retire.r2;
      pct_pkg::sel_r3: sel_val = retire.r3;
      pct_pkg::sel_r4: sel_val = retire.r4;
      pct_pkg::sel_r5: sel_val = retire.r5;
      default:         sel_val = '0;
    endcase
  end

  assign equal_hit  = (watch_cfg.mode == pct_pkg::watch_equal) &&
                      ((sel_val & watch_cfg.mask) == (watch_cfg.value & watch_cfg.mask));
  // No previous value yet means no change
  assign change_hit = (watch_cfg.mode == pct_pkg::watch_change) &&
                      seen_first && (sel_val != prev_val);

  // --------------------------------------------------
  // Hit register and change history
  // --------------------------------------------------
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      watch_hit  <= 1'b0;
      seen_first <= 1'b0;
    end else begin
      watch_hit <= retire.valid && (equal_hit || change_hit);
      // History restarts whenever change mode is left,
      // so the first retire after entering it never hits
      if (watch_cfg.mode != pct_pkg::watch_change) begin
        seen_first <= 1'b0;
      end else if (retire.valid) begin
        seen_first <= 1'b1;
      end
    end
  end

  always_ff @(posedge clks) begin
    if (retire.valid && (watch_cfg.mode == pct_pkg::watch_change)) begin
      prev_val <= sel_val;
    end
  end

  // Register file must only hand over a defined selection
  sel_legal_a: assert property (@(posedge clks) disable iff (!rst_n)
    watch_cfg.sel inside {pct_pkg::sel_r1, pct_pkg::sel_r2, pct_pkg::sel_r3,
                          pct_pkg::sel_r4, pct_pkg::sel_r5});

endmodule

/* verilog/trace_capture.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module trace_capture (
  input  logic                         clks,
  input  logic                         rst_n,
  input  logic                         enable,
  input  logic [`PCT_NUM_TRIGGERS-1:0] trig_hits,
  input  logic [31:0]                  hit_pc,
  input  logic                         hit_valid,
  input  logic                         watch_hit,
  input  logic                         pop,
  output pct_pkg::trace_rec_t          head,
  output pct_pkg::fifo_status_t        status,
  input  logic                         overflow_clr
);

  localparam int DEPTH = `PCT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  pct_pkg::trace_rec_t     mem [DEPTH];
  pct_pkg::trace_rec_t     rec;
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  logic [`PCT_STAMP_W-1:0] stamp_cnt;
  logic                    overflow;
  logic                    push_req;
  logic                    full;
  logic                    do_push;
  logic                    do_pop;

  // --------------------------------------------------
  // Record build
  // --------------------------------------------------
  assign push_req = hit_valid && enable && ((|trig_hits) || watch_hit);
  assign full     = (count == CNT_W'(DEPTH));
  assign do_push  = push_req && !full;
  assign do_pop   = pop && (count != '0);

  always_comb begin
    rec.pc        = hit_pc;
    rec.stamp     = stamp_cnt;
    rec.watch_hit = watch_hit;
    rec.trig_hits = trig_hits;
  end

  // Retires counted while enabled, wraps at stamp width
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      stamp_cnt <= '0;
    end else if (hit_valid && enable) begin
      stamp_cnt <= stamp_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // Circular FIFO
  // --------------------------------------------------
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
      // A drop in the same cycle wins over the clear
      if (overflow_clr) begin
        overflow <= 1'b0;
      end
      if (push_req && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clks) begin
    if (do_push) begin
      mem[wr_ptr] <= rec;
    end
  end

  assign head = mem[rd_ptr];

  always_comb begin
    status.count    = count;
    status.empty    = (count == '0);
    status.overflow = overflow;
  end

  // Register file gates HEAD_INFO pops on empty
  pop_not_empty_a: assert property (@(posedge clks) disable iff (!rst_n)
    pop |-> (count != '0));

  count_bound_a: assert property (@(posedge clks) disable iff (!rst_n)
    count <= CNT_W'(DEPTH));

endmodule

/* verilog/pct_apb_regs.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module pct_apb_regs (
  input  logic                               clks,
  input  logic                               rst_n,
  input  logic [`PCT_APB_AW-1:0]             paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               enable,
  output logic                               overflow_clr,
  output logic [`PCT_NUM_TRIGGERS-1:0]       trig_en,
  output logic [`PCT_NUM_TRIGGERS-1:0][31:0] trig_addr,
  output pct_pkg::watch_cfg_t                watch_cfg,
  output logic                               pop,
  input  pct_pkg::trace_rec_t                head,
  input  pct_pkg::fifo_status_t              status
);

  localparam int IDX_W = $clog2(`PCT_NUM_TRIGGERS);

  logic             wr_access;
  logic             rd_access;
  logic             trig_sel;
  logic [IDX_W-1:0] trig_idx;
  logic [31:0]      rdata;

  // Zero wait states and no error responses
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  assign wr_access = psel && penable && pwrite;
  assign rd_access = psel && penable && !pwrite;

  // Trigger address window of one word per trigger
  assign trig_sel = (paddr >= `PCT_REG_TRIG_ADDR0) &&
                    (paddr < (`PCT_REG_TRIG_ADDR0 + 4 * `PCT_NUM_TRIGGERS));
  assign trig_idx = paddr[2 +: IDX_W];

  // --------------------------------------------------
  // Configuration writes
  // --------------------------------------------------
  always_ff @(posedge clks) begin
    if (!rst_n) begin
      enable         <= 1'b0;
      trig_en        <= '0;
      watch_cfg.mode <= pct_pkg::watch_off;
      watch_cfg.sel  <= pct_pkg::sel_r1;
    end else if (wr_access) begin
      if (paddr == `PCT_REG_CTRL) begin
        enable <= pwdata[0];
      end
      if (paddr == `PCT_REG_TRIG_EN) begin
        trig_en <= pwdata[`PCT_NUM_TRIGGERS-1:0];
      end
      if (paddr == `PCT_REG_WATCH_CFG) begin
        // Undefined encodings leave the field unchanged
        if (pwdata[1:0] != 2'd3) begin
          watch_cfg.mode <= pct_pkg::watch_mode_e'(pwdata[1:0]);
        end
        if (pwdata[6:4] <= 3'd4) begin
          watch_cfg.sel <= pct_pkg::watch_sel_e'(pwdata[6:4]);
        end
      end
      if (paddr == `PCT_REG_WATCH_VALUE) begin
        watch_cfg.value <= pwdata;
      end
      if (paddr == `PCT_REG_WATCH_MASK) begin
        watch_cfg.mask <= pwdata;
      end
    end
  end

  always_ff @(posedge clks) begin
    if (wr_access) begin
      if (trig_sel) begin
        trig_addr[trig_idx] <= pwdata;
      end
    end
  end

  // Write-one pulse that is never stored
  assign overflow_clr = wr_access && (paddr == `PCT_REG_CTRL) && pwdata[1];

  // HEAD_INFO read advances the FIFO as the access phase ends
  assign pop = rd_access && (paddr == `PCT_REG_HEAD_INFO) && !status.empty;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    rdata = '0;
    if (trig_sel) begin
      rdata = trig_addr[trig_idx];
    end else begin
      case (paddr)
        `PCT_REG_CTRL:        rdata[0] = enable;
        `PCT_REG_TRIG_EN:     rdata[`PCT_NUM_TRIGGERS-1:0] = trig_en;
        `PCT_REG_WATCH_VALUE: rdata = watch_cfg.value;
        `PCT_REG_WATCH_MASK:  rdata = watch_cfg.mask;
        `PCT_REG_WATCH_CFG: begin
          rdata[1:0] = watch_cfg.mode;
          rdata[6:4] = watch_cfg.sel;
        end
        `PCT_REG_STATUS: begin
          rdata    = 32'(status.count);
          rdata[8] = status.empty;
          rdata[9] = status.overflow;
        end
        `PCT_REG_HEAD_PC: begin
          if (!status.empty) begin
            rdata = head.pc;
          end
        end
        `PCT_REG_HEAD_INFO: begin
          if (!status.empty) begin
            rdata[31 -: `PCT_STAMP_W]       = head.stamp;
            rdata[4]                        = head.watch_hit;
            rdata[`PCT_NUM_TRIGGERS-1:0]    = head.trig_hits;
          end
        end
        default: rdata = '0;
      endcase
    end
  end

  assign prdata = rdata;

  // Access phase only ever follows a selected setup phase
  penable_in_psel_a: assert property (@(posedge clks) disable iff (!rst_n)
    penable |-> psel);

endmodule

/* verilog/pc_trace_top.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module pc_trace_top (
  input  logic                   clks,
  input  logic                   rst_n,
  input  pct_pkg::retire_t       retire,
  input  logic [`PCT_APB_AW-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);

  // Configuration from the register file
  logic                               enable;
  logic                               overflow_clr;
  logic [`PCT_NUM_TRIGGERS-1:0]       trig_en;
  logic [`PCT_NUM_TRIGGERS-1:0][31:0] trig_addr;
  pct_pkg::watch_cfg_t                watch_cfg;

  // FIFO side
  logic                               pop;
  pct_pkg::trace_rec_t                head;
  pct_pkg::fifo_status_t              status;

  // Both detectors fill one result word
  wire pct_pkg::hit_t                 hits;

  // --------------------------------------------------
  // Detectors
  // --------------------------------------------------
  pc_trigger_match trig_i (
    .clks      (clks),
    .rst_n     (rst_n),
    .retire    (retire),
    .trig_en   (trig_en),
    .trig_addr (trig_addr),
    .trig_hits (hits.trig_hits),
    .hit_pc    (hits.pc),
    .hit_valid (hits.valid)
  );

  data_watch watch_i (
    .clks      (clks),
    .rst_n     (rst_n),
    .retire    (retire),
    .watch_cfg (watch_cfg),
    .watch_hit (hits.watch_hit)
  );

  // --------------------------------------------------
  // Capture and register file
  // --------------------------------------------------
  trace_capture capture_i (
    .clks         (clks),
    .rst_n        (rst_n),
    .enable       (enable),
    .trig_hits    (hits.trig_hits),
    .hit_pc       (hits.pc),
    .hit_valid    (hits.valid),
    .watch_hit    (hits.watch_hit),
    .pop          (pop),
    .head         (head),
    .status       (status),
    .overflow_clr (overflow_clr)
  );

  pct_apb_regs regs_i (
    .clks         (clks),
    .rst_n        (rst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .enable       (enable),
    .overflow_clr (overflow_clr),
    .trig_en      (trig_en),
    .trig_addr    (trig_addr),
    .watch_cfg    (watch_cfg),
    .pop          (pop),
    .head         (head),
    .status       (status)
  );

endmodule

/* test/pc_trace_checker.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module pc_trace_checker (
  input logic                   clks,
  input logic                   rst_n,
  input pct_pkg::retire_t       retire,
  input logic [`PCT_APB_AW-1:0] paddr,
  input logic                   psel,
  input logic                   penable,
  input logic                   pwrite,
  input logic [31:0]            pwdata,
  input logic [31:0]            prdata
);

  int errors = 0;

  // Reference copy of the configuration and the record queue
  pct_pkg::trace_rec_t          rec_q[$];
  pct_pkg::watch_mode_e         mode_m;
  logic [2:0]                   sel_m;
  logic                         enable_m;
  logic [`PCT_NUM_TRIGGERS-1:0] trig_en_m;
  logic [31:0]                  trig_addr_m [`PCT_NUM_TRIGGERS];
  logic [31:0]                  value_m;
  logic [31:0]                  mask_m;
  logic [31:0]                  prev_m;
  logic                         seen_m;
  logic                         ovf_m;
  logic [`PCT_STAMP_W-1:0]      stamp_m;

  task automatic compare(input string name, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      $display("FAILED %s: expected %h, got %h", name, want, got);
      errors++;
    end
  endtask

  task automatic apply_write(input logic [`PCT_APB_AW-1:0] a, input logic [31:0] d);
    case (a)
      `PCT_REG_CTRL: begin
        enable_m = d[0];
        if (d[1]) begin
          ovf_m = 1'b0;
        end
      end
      `PCT_REG_TRIG_EN:     trig_en_m = d[`PCT_NUM_TRIGGERS-1:0];
      `PCT_REG_TRIG_ADDR0,
      `PCT_REG_TRIG_ADDR1,
      `PCT_REG_TRIG_ADDR2,
      `PCT_REG_TRIG_ADDR3:  trig_addr_m[(a - `PCT_REG_TRIG_ADDR0) >> 2] = d;
      `PCT_REG_WATCH_VALUE: value_m = d;
      `PCT_REG_WATCH_MASK:  mask_m = d;
      `PCT_REG_WATCH_CFG: begin
        mode_m = pct_pkg::watch_mode_e'(d[1:0]);
        sel_m  = d[6:4];
        // Change history only lives while in change mode
        if (mode_m != pct_pkg::watch_change) begin
          seen_m = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  // --------------------------------------------------
  // Reference model of one retire
  // --------------------------------------------------
  task automatic model_retire(input pct_pkg::retire_t r);
    logic [31:0]                  v;
    logic [`PCT_NUM_TRIGGERS-1:0] trig;
    logic                         watch;
    pct_pkg::trace_rec_t          rec;
    case (sel_m)
      3'd0:    v = r.r1;
      3'd1:    v = r.r2;
      3'd2:    v = r.r3;
      3'd3:    v = r.r4;
      default: v = r.r5;
    endcase
    trig = '0;
    for (int i = 0; i < `PCT_NUM_TRIGGERS; i++) begin
      if (trig_en_m[i] && (r.pc == trig_addr_m[i])) begin
        trig[i] = 1'b1;
      end
    end
    watch = 1'b0;
    if (mode_m == pct_pkg::watch_equal) begin
      watch = (((v ^ value_m) & mask_m) == 32'h0);
    end else if (mode_m == pct_pkg::watch_change) begin
      watch  = seen_m && (v != prev_m);
      prev_m = v;
      seen_m = 1'b1;
    end
    if (enable_m) begin
      if ((trig != '0) || watch) begin
        if (rec_q.size() < `PCT_FIFO_DEPTH) begin
          rec.pc        = r.pc;
          rec.stamp     = stamp_m;
          rec.watch_hit = watch;
          rec.trig_hits = trig;
          rec_q.push_back(rec);
        end else begin
          ovf_m = 1'b1;
        end
      end
      stamp_m = stamp_m + 1'b1;
    end
  endtask

  task automatic check_read(input logic [`PCT_APB_AW-1:0] a, input logic [31:0] got);
    logic [31:0] want;
    want = 32'h0;
    case (a)
      `PCT_REG_STATUS: begin
        want    = 32'(rec_q.size());
        want[8] = (rec_q.size() == 0);
        want[9] = ovf_m;
        compare("status", want, got);
      end
      `PCT_REG_HEAD_PC: begin
        if (rec_q.size() != 0) begin
          want = rec_q[0].pc;
        end
        compare("head_pc", want, got);
      end
      `PCT_REG_HEAD_INFO: begin
        if (rec_q.size() != 0) begin
          want = {rec_q[0].stamp, 11'h0, rec_q[0].watch_hit, rec_q[0].trig_hits};
          void'(rec_q.pop_front());
        end
        compare("head_info", want, got);
      end
      default: ;
    endcase
  endtask

  always @(posedge clks) begin
    if (!rst_n) begin
      rec_q.delete();
      mode_m    = pct_pkg::watch_off;
      sel_m     = 3'd0;
      enable_m  = 1'b0;
      trig_en_m = '0;
      seen_m    = 1'b0;
      ovf_m     = 1'b0;
      stamp_m   = '0;
    end else begin
      if (psel && penable && pwrite) begin
        apply_write(paddr, pwdata);
      end
      if (psel && penable && !pwrite) begin
        check_read(paddr, prdata);
      end
      if (retire.valid) begin
        model_retire(retire);
      end
    end
  end

endmodule

/* test/tb_pc_trace.sv */
`timescale 1ns/1ps

`include "pct_consts.svh"

module tb_pc_trace;

  localparam int APB_TIMEOUT = 16;
  localparam int NUM_ROWS    = 29;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] r2;
    logic [4:0]  hits;
  } row_t;

  logic                   clks;
  logic                   rst_n;
  pct_pkg::retire_t       retire;
  logic [`PCT_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  logic [15:0] lfsr_state;
  logic [4:0]  exp_q[$];
  int          tb_errors;

  // Columns are pc, r2, expected hits as {watch, trig[3:0]}
  row_t rows [NUM_ROWS] = '{
    // Capture disabled
    '{32'h0000_0100, 32'h0000_0000, 5'h00},
    '{32'h0000_0104, 32'h0000_0000, 5'h00},
    // Two address triggers
    '{32'h0000_0100, 32'h0000_0000, 5'h01},
    '{32'h0000_0104, 32'h0000_0000, 5'h00},
    '{32'h0000_0200, 32'h0000_0000, 5'h02},
    '{32'h0000_0300, 32'h0000_0000, 5'h00},
    // Both triggers on one address
    '{32'h0000_0100, 32'h0000_0000, 5'h03},
    '{32'h0000_0200, 32'h0000_0000, 5'h00},
    // Masked equal on r2
    '{32'h0000_0400, 32'h1234_5A77, 5'h10},
    '{32'h0000_0404, 32'h0000_5B00, 5'h00},
    '{32'h0000_0408, 32'hFFFF_5A00, 5'h10},
    // Change on r2
    '{32'h0000_040C, 32'h0000_0010, 5'h00},
    '{32'h0000_0410, 32'h0000_0010, 5'h00},
    '{32'h0000_0414, 32'h0000_0020, 5'h10},
    '{32'h0000_0418, 32'h0000_0020, 5'h00},
    '{32'h0000_041C, 32'h0000_0030, 5'h10},
    // Trigger and watch together
    '{32'h0000_0100, 32'h0000_5A01, 5'h11},
    '{32'h0000_0100, 32'h0000_6A00, 5'h01},
    '{32'h0000_0500, 32'h7F00_5AFF, 5'h10},
    // Ten hits for a FIFO of eight
    '{32'h0000_0100, 32'h0000_0001, 5'h01},
    '{32'h0000_0100, 32'h0000_0002, 5'h01},
    '{32'h0000_0100, 32'h0000_0003, 5'h01},
    '{32'h0000_0100, 32'h0000_0004, 5'h01},
    '{32'h0000_0100, 32'h0000_0005, 5'h01},
    '{32'h0000_0100, 32'h0000_0006, 5'h01},
    '{32'h0000_0100, 32'h0000_0007, 5'h01},
    '{32'h0000_0100, 32'h0000_0008, 5'h01},
    '{32'h0000_0100, 32'h0000_0009, 5'h01},
    '{32'h0000_0100, 32'h0000_000A, 5'h01}
  };

  pc_trace_top dut_i (
    .clks    (clks),
    .rst_n   (rst_n),
    .retire  (retire),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  pc_trace_checker checker_i (
    .clks    (clks),
    .rst_n   (rst_n),
    .retire  (retire),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata)
  );

  always #5 clks = ~clks;

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      w[b] = lfsr_state[0];
    end
    return w;
  endfunction

  task automatic apb_access(input logic wr, input logic [`PCT_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic ready_seen;
    logic err_seen;
    @(posedge clks);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clks);
    #1;
    penable = 1'b1;
    waited  = 0;
    // Response sampled mid-cycle before the closing edge
    #1;
    while (!pready && (waited < APB_TIMEOUT)) begin
      @(posedge clks);
      #2;
      waited++;
    end
    rdata      = prdata;
    ready_seen = pready;
    err_seen   = pslverr;
    @(posedge clks);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    if (!ready_seen) begin
      $display("APB access to address %h got no pready within %0d cycles", addr, APB_TIMEOUT);
      $display("Test failed");
      $finish;
    end else if (err_seen !== 1'b0) begin
      $display("FAILED pslverr: expected %h, got %h", 1'b0, err_seen);
      tb_errors++;
    end
  endtask

  task automatic write_reg(input logic [`PCT_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input logic [`PCT_APB_AW-1:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'h0, data);
  endtask

  // One row per cycle with the other registers random
  task automatic apply_rows(input int first, input int last);
    pct_pkg::retire_t r;
    for (int i = first; i <= last; i++) begin
      r.valid = 1'b1;
      r.pc    = rows[i].pc;
      r.r1    = random_word();
      r.r2    = rows[i].r2;
      r.r3    = random_word();
      r.r4    = random_word();
      r.r5    = random_word();
      if ((rows[i].hits != 5'h0) && (exp_q.size() < `PCT_FIFO_DEPTH)) begin
        exp_q.push_back(rows[i].hits);
      end
      @(posedge clks);
      #1;
      retire = r;
    end
    @(posedge clks);
    #1;
    retire.valid = 1'b0;
  endtask

  // Reads every record and matches its flags against the table
  task automatic drain_fifo();
    logic [31:0] status_word;
    logic [31:0] pc_word;
    logic [31:0] info_word;
    logic [4:0]  want;
    int          n;
    read_reg(`PCT_REG_STATUS, status_word);
    n = int'(status_word[3:0]);
    if (n != exp_q.size()) begin
      $display("FAILED record count: expected %h, got %h", exp_q.size(), n);
      tb_errors++;
    end
    for (int k = 0; k < n; k++) begin
      read_reg(`PCT_REG_HEAD_PC, pc_word);
      read_reg(`PCT_REG_HEAD_INFO, info_word);
      if (exp_q.size() == 0) begin
        $display("Record %0d was read back with no stimulus row that should produce it", k);
        tb_errors++;
      end else begin
        want = exp_q.pop_front();
        if (info_word[4:0] != want) begin
          $display("FAILED head_info hits: expected %h, got %h", want, info_word[4:0]);
          tb_errors++;
        end
      end
    end
    exp_q.delete();
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] rd;
    clks       = 1'b0;
    rst_n      = 1'b0;
    retire     = '0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    lfsr_state = 16'd49;
    tb_errors  = 0;
    repeat (10) @(posedge clks);
    #1;
    rst_n = 1'b1;

    read_reg(`PCT_REG_STATUS, rd);
    write_reg(`PCT_REG_TRIG_ADDR0, 32'h0000_0100);
    write_reg(`PCT_REG_TRIG_EN, 32'h1);
    apply_rows(0, 1);
    drain_fifo();

    write_reg(`PCT_REG_TRIG_ADDR1, 32'h0000_0200);
    write_reg(`PCT_REG_TRIG_EN, 32'h3);
    write_reg(`PCT_REG_CTRL, 32'h1);
    apply_rows(2, 5);
    drain_fifo();
    write_reg(`PCT_REG_TRIG_ADDR1, 32'h0000_0100);
    apply_rows(6, 7);
    drain_fifo();

    // Watch r2 with mode in bits 1:0 and select in bits 6:4
    write_reg(`PCT_REG_TRIG_EN, 32'h0);
    write_reg(`PCT_REG_WATCH_VALUE, 32'h0000_5A00);
    write_reg(`PCT_REG_WATCH_MASK, 32'h0000_FF00);
    write_reg(`PCT_REG_WATCH_CFG, 32'h11);
    apply_rows(8, 10);
    drain_fifo();
    write_reg(`PCT_REG_WATCH_CFG, 32'h12);
    apply_rows(11, 15);
    drain_fifo();

    write_reg(`PCT_REG_WATCH_CFG, 32'h11);
    write_reg(`PCT_REG_TRIG_EN, 32'h1);
    apply_rows(16, 18);
    drain_fifo();

    write_reg(`PCT_REG_WATCH_CFG, 32'h00);
    apply_rows(19, 28);
    read_reg(`PCT_REG_STATUS, rd);
    write_reg(`PCT_REG_CTRL, 32'h3);
    drain_fifo();
    read_reg(`PCT_REG_STATUS, rd);

    $display("Errors: testbench %0d, checker %0d", tb_errors, checker_i.errors);
    if ((tb_errors + checker_i.errors) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/pct_pkg.sv
verilog/pc_trigger_match.sv
verilog/data_watch.sv
verilog/trace_capture.sv
verilog/pct_apb_regs.sv
verilog/pc_trace_top.sv
test/pc_trace_checker.sv
test/tb_pc_trace.sv

/* Makefile */
# Verilator build and run for the PC trace unit

VERILATOR ?= verilator
TOP       ?= tb_pc_trace
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
